// ==== rtl/router_defines.svh ====
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// ports of the mesh router.
// order is Local, North, East, West, South.
`define NUM_PORTS 5

// flit field widths.
`define FLIT_ID_W 3
`define LEN_W 12
`define PAYLOAD_W 16

// flit id of a head flit.
// the length field is only meaningful on a head flit.
`define HEAD_ID 1

// one extra state bit for idle.
`define ARB_STATE_W (`NUM_PORTS + 1)

`endif

// ==== rtl/routerPkg.sv ====
`default_nettype none

`include "router_defines.svh"

package routerPkg;

  typedef logic [`FLIT_ID_W-1:0] flitId_t;

  // packet length, also the hold limit of a grant.
  typedef logic [`LEN_W-1:0] pktLen_t;

  typedef logic [`PAYLOAD_W-1:0] payload_t;

  // bit 0 is Local, then North, East, West and South.
  typedef logic [`NUM_PORTS-1:0] portVec_t;

  typedef struct packed {
    flitId_t  flitId;
    pktLen_t  length;
    payload_t payload;
  } flit_t;

  // one flit per input port, indexed by port.
  typedef flit_t [`NUM_PORTS-1:0] flitArray_t;

  // one-hot arbiter state.
  // bit 0 is idle, bit p+1 grants port p.
  typedef enum logic [`ARB_STATE_W-1:0] {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbState_t;

endpackage : routerPkg

`default_nettype wire

// ==== rtl/holdTimer.sv ====
`default_nettype none

`include "router_defines.svh"

module holdTimer
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire routerPkg::flitId_t flitId,
  input  wire routerPkg::pktLen_t length,
  input  wire logic               run,
  output logic                    timesUp
);

  import routerPkg::*;

  pktLen_t holdLen;
  pktLen_t holdCount;
  logic    isHead;

  assign isHead = (flitId == flitId_t'(`HEAD_ID));

  // head flit sets the limit, granted or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
    end
    else if (isHead)
    begin
      holdLen <= length;
    end
  end

  // counts granted cycles, clears as soon as the port leaves.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdCount <= '0;
    end
    else if (run)
    begin
      holdCount <= holdCount + pktLen_t'(1);
    end
    else
    begin
      holdCount <= '0;
    end
  end

  assign timesUp = (holdCount == holdLen);

endmodule : holdTimer

`default_nettype wire

// ==== rtl/switchArbiter.sv ====
`default_nettype none

`include "router_defines.svh"

module switchArbiter
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire routerPkg::flitArray_t inFlits,
  input  wire routerPkg::portVec_t   req,
  output routerPkg::portVec_t        grant
);

  import routerPkg::*;

  // port positions in request and grant vectors.
  localparam int unsigned portL = 0;
  localparam int unsigned portN = 1;
  localparam int unsigned portE = 2;
  localparam int unsigned portW = 3;
  localparam int unsigned portS = 4;

  arbState_t state;
  arbState_t nextState;
  portVec_t  run;
  portVec_t  timesUp;

  // first requester after port cur, in circular order.
  // cur itself is checked last.
  function automatic arbState_t pickAfter
  (
    input portVec_t    reqs,
    input int unsigned cur
  );
    arbState_t   pick;
    logic        found;
    int unsigned idx;
    pick  = ST_IDLE;
    found = 1'b0;
    for (int unsigned k = 1; k <= `NUM_PORTS; k++)
    begin
      idx = (cur + k) % `NUM_PORTS;
      if (!found && reqs[idx])
      begin
        pick  = arbState_t'(6'b000010 << idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    holdTimer holdTimer_inst
    (
      .clk     (clk),
      .rst     (rst),
      .flitId  (inFlits[p].flitId),
      .length  (inFlits[p].length),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    run       = '0;
    nextState = ST_IDLE;
    case (state)
      // from idle, Local has the highest priority.
      ST_IDLE:
      begin
        nextState = pickAfter(req, portS);
      end
      ST_L:
      begin
        if (req[portL] && !timesUp[portL])
        begin
          run[portL] = 1'b1;
          nextState  = ST_L;
        end
        else
        begin
          nextState = pickAfter(req, portL);
        end
      end
      ST_N:
      begin
        if (req[portN] && !timesUp[portN])
        begin
          run[portN] = 1'b1;
          nextState  = ST_N;
        end
        else
        begin
          nextState = pickAfter(req, portN);
        end
      end
      ST_E:
      begin
        if (req[portE] && !timesUp[portE])
        begin
          run[portE] = 1'b1;
          nextState  = ST_E;
        end
        else
        begin
          nextState = pickAfter(req, portE);
        end
      end
      ST_W:
      begin
        if (req[portW] && !timesUp[portW])
        begin
          run[portW] = 1'b1;
          nextState  = ST_W;
        end
        else
        begin
          nextState = pickAfter(req, portW);
        end
      end
      ST_S:
      begin
        if (req[portS] && !timesUp[portS])
        begin
          run[portS] = 1'b1;
          nextState  = ST_S;
        end
        else
        begin
          nextState = pickAfter(req, portS);
        end
      end
      default:
      begin
        nextState = ST_IDLE;
      end
    endcase
  end

  // state without the idle bit, so one-hot or zero.
  assign grant = state[`NUM_PORTS:1];

endmodule : switchArbiter

`default_nettype wire

// ==== rtl/grantMux.sv ====
`default_nettype none

`include "router_defines.svh"

module grantMux
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire routerPkg::flitArray_t inFlits,
  input  wire routerPkg::portVec_t   grant,
  output routerPkg::flit_t           outFlit,
  output logic                       outValid
);

  import routerPkg::*;

  flit_t selFlit;
  logic  anyGrant;

  assign anyGrant = |grant;

  // and-or select, grant is one-hot.
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        selFlit = selFlit | inFlits[p];
      end
    end
  end

  // last forwarded flit stays when nobody is granted.
  always_ff @(posedge clk)
  begin
    if (anyGrant)
    begin
      outFlit <= selFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= anyGrant;
    end
  end

endmodule : grantMux

`default_nettype wire

// ==== rtl/routerSwitch.sv ====
`default_nettype none

module routerSwitch
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire routerPkg::flitArray_t inFlits,
  input  wire routerPkg::portVec_t   req,
  output routerPkg::portVec_t        grant,
  output routerPkg::flit_t           outFlit,
  output logic                       outValid
);

  import routerPkg::*;

  portVec_t arbGrant;

  // grant follows the request edge by one cycle.
  switchArbiter switchArbiter_inst
  (
    .clk     (clk),
    .rst     (rst),
    .inFlits (inFlits),
    .req     (req),
    .grant   (arbGrant)
  );

  // output flit lags the grant by one more cycle.
  grantMux grantMux_inst
  (
    .clk      (clk),
    .rst      (rst),
    .inFlits  (inFlits),
    .grant    (arbGrant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  assign grant = arbGrant;

endmodule : routerSwitch

`default_nettype wire

// ==== dv/routerSwitchTb.sv ====
`default_nettype none

`include "router_defines.svh"

module routerSwitchTb;

  timeunit 1ns;
  timeprecision 1ps;

  import routerPkg::*;

  typedef pktLen_t [`NUM_PORTS-1:0] lenArray_t;

  localparam int directedCycles = 120;
  localparam int randomCycles   = 1080;
  localparam int timeoutCycles  = (directedCycles + randomCycles) * 3 / 2;

  logic       clk;
  logic       rst;
  flitArray_t inFlits;
  portVec_t   req;
  portVec_t   grant;
  flit_t      outFlit;
  logic       outValid;

  // reference model of arbiter, timers and output register.
  arbState_t mState = ST_IDLE;
  lenArray_t mLen = '0;
  lenArray_t mCount = '0;
  flit_t     mOutFlit = '0;
  logic      mOutValid = 1'b0;
  logic      mHasFlit = 1'b0;

  int grantErrors = 0;
  int validErrors = 0;
  int flitErrors = 0;
  int stimCount = 0;
  int cycleCount = 0;
  integer seed = 36;

  routerSwitch routerSwitch_inst
  (
    .clk      (clk),
    .rst      (rst),
    .inFlits  (inFlits),
    .req      (req),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int portOf(arbState_t st);
    case (st)
      ST_L: return 0;
      ST_N: return 1;
      ST_E: return 2;
      ST_W: return 3;
      ST_S: return 4;
      default: return -1;
    endcase
  endfunction

  function automatic arbState_t stateOf(int p);
    case (p)
      0: return ST_L;
      1: return ST_N;
      2: return ST_E;
      3: return ST_W;
      4: return ST_S;
      default: return ST_IDLE;
    endcase
  endfunction

  function automatic portVec_t grantOf(arbState_t st);
    portVec_t g;
    g = '0;
    if (portOf(st) >= 0)
    begin
      g[portOf(st)] = 1'b1;
    end
    return g;
  endfunction

  // idle scans from Local, a port state scans from the port after it.
  function automatic arbState_t nextArb
  (
    input arbState_t st,
    input portVec_t  r,
    input lenArray_t len,
    input lenArray_t cnt
  );
    int cur;
    int start;
    int idx;
    cur = portOf(st);
    if (cur >= 0 && r[cur] && cnt[cur] != len[cur])
    begin
      return st;
    end
    start = (cur < 0) ? 0 : cur + 1;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = (start + k) % `NUM_PORTS;
      if (r[idx])
      begin
        return stateOf(idx);
      end
    end
    return ST_IDLE;
  endfunction

  task automatic checkGrant(input portVec_t exp, input portVec_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED time=%0t signal=grant expected=%b actual=%b", $time, exp, act);
      grantErrors++;
    end
  endtask

  task automatic checkValid(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED time=%0t signal=outValid expected=%b actual=%b", $time, exp, act);
      validErrors++;
    end
  endtask

  task automatic checkFlit(input flit_t exp, input flit_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED time=%0t signal=outFlit expected=%h actual=%h", $time, exp, act);
      flitErrors++;
    end
  endtask

  // inputs seen here are the ones the next rising edge samples.
  task stepModel();
    int        cur;
    logic      hold;
    arbState_t nxt;
    if (rst)
    begin
      mState    = ST_IDLE;
      mLen      = '0;
      mCount    = '0;
      mOutValid = 1'b0;
    end
    else
    begin
      cur  = portOf(mState);
      hold = (cur >= 0) && req[cur] && (mCount[cur] != mLen[cur]);
      nxt  = nextArb(mState, req, mLen, mCount);
      mOutValid = (cur >= 0);
      if (cur >= 0)
      begin
        mOutFlit = inFlits[cur];
        mHasFlit = 1'b1;
      end
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (hold && p == cur)
        begin
          mCount[p] = mCount[p] + pktLen_t'(1);
        end
        else
        begin
          mCount[p] = '0;
        end
        if (inFlits[p].flitId == flitId_t'(`HEAD_ID))
        begin
          mLen[p] = inFlits[p].length;
        end
      end
      mState = nxt;
    end
  endtask

  // compare on the falling edge, away from both input and output changes.
  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkGrant(grantOf(mState), grant);
      checkValid(mOutValid, outValid);
      if (mHasFlit)
      begin
        checkFlit(mOutFlit, outFlit);
      end
    end
    stepModel();
  end

  task automatic waitCycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
      stimCount++;
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        inFlits[p].payload = payload_t'(stimCount * 8 + p);
      end
    end
  endtask

  task automatic setHead(input int p, input pktLen_t len);
    inFlits[p].flitId = flitId_t'(`HEAD_ID);
    inFlits[p].length = len;
  endtask

  task automatic setBody(input int p);
    inFlits[p].flitId = 3'd2;
  endtask

  task automatic randomCycle();
    logic [31:0] rnd;
    @(posedge clk);
    #2;
    rnd = $random(seed);
    req = rnd[`NUM_PORTS-1:0];
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      rnd = $random(seed);
      inFlits[p].flitId  = rnd[2:0];
      inFlits[p].length  = pktLen_t'(rnd[6:4]);
      inFlits[p].payload = rnd[31:16];
    end
  endtask

  initial
  begin
    while (cycleCount < timeoutCycles)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the test did not finish within %0d cycles", timeoutCycles);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    rst     = 1'b1;
    req     = '0;
    inFlits = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    // quiet cycles, no grant expected.
    waitCycles(4);
    setHead(0, 12'd3);
    setHead(1, 12'd2);
    setHead(2, 12'd4);
    setHead(3, 12'd1);
    setHead(4, 12'd0);
    waitCycles(1);
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      setBody(p);
    end
    waitCycles(1);
    // North, East and West together, North first.
    req = 5'b01110;
    waitCycles(14);
    req = 5'b00100;
    waitCycles(3);
    req = '0;
    waitCycles(3);
    // new West length lands while Local holds.
    req = 5'b00001;
    waitCycles(2);
    setHead(3, 12'd6);
    waitCycles(1);
    setBody(3);
    req = 5'b01001;
    waitCycles(16);
    // South with zero length, alone and then shared.
    req = 5'b10000;
    waitCycles(4);
    req = 5'b10001;
    waitCycles(8);
    req = 5'b11111;
    waitCycles(30);
    req = '0;
    waitCycles(3);
    repeat (randomCycles)
    begin
      randomCycle();
    end
    req = '0;
    waitCycles(4);
    $display("errors: grant %0d, outValid %0d, outFlit %0d", grantErrors, validErrors,
             flitErrors);
    if (grantErrors + validErrors + flitErrors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/routerPkg.sv
rtl/holdTimer.sv
rtl/switchArbiter.sv
rtl/grantMux.sv
rtl/routerSwitch.sv
dv/routerSwitchTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := routerSwitchTb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard rtl/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
